// File: list.f
+incdir+verification
common/mbus_frame_pkg.sv
common/mbus_power_pkg.sv
common/mbus_msg_if.sv
node/mbus_rx_frame.sv
node/mbus_tx_frame.sv
design/mbus_wire_ctrl.sv
design/mbus_sleep_ctrl.sv
design/mbus_layer_wrapper.sv
verification/mbus_layer_wrapper_tb.sv

// File: verification/mbus_tb_tasks.svh
`ifndef MBUS_TB_TASKS_SVH
`define MBUS_TB_TASKS_SVH

// line held high for a number of cycles
task automatic idle_line(input int cycles);
	repeat (cycles)
	begin
		@(negedge clkin);
		din = 1'b1;
	end
endtask

// start bit, address, data, stop bit; MSB first, one bit per falling edge
task automatic send_frame(input logic [7:0] addr, input logic [31:0] data);
	logic [41:0] frame;
	frame = {1'b0, addr, data, 1'b1};
	for (int i = 41; i >= 0; i--)
	begin
		@(negedge clkin);
		din = frame[i];
	end
	@(negedge clkin);
	din = 1'b1;
endtask

// called right after the tx_ack edge; samples dout between edges
task automatic capture_frame(output logic [41:0] frame);
	frame = '0;
	@(posedge clkin);
	for (int i = 41; i >= 0; i--)
	begin
		@(negedge clkin);
		frame[i] = dout;
	end
	// stop bit is on dout in this cycle, and so is the success pulse
	assert (tx_succ === 1'b1)
	else
		fail_test($sformatf("MISMATCH tx_succ got %h expected 1", tx_succ));
endtask

// tx_req held with stable fields until tx_ack, then dropped
task automatic transmit_frame(input logic [7:0] addr, input logic [31:0] data,
	output logic [41:0] frame);
	int n;
	@(negedge clkin);
	tx_addr = addr;
	tx_data = data;
	tx_req = 1'b1;
	#1;
	n = 0;
	while (tx_ack !== 1'b1 && n < 100)
	begin
		@(negedge clkin);
		#1;
		n++;
	end
	if (tx_ack !== 1'b1)
		fail_test("timeout waiting for tx_ack");
	@(posedge clkin);
	fork
		capture_frame(frame);
		begin
			@(negedge clkin);
			tx_req = 1'b0;
		end
	join
endtask

`endif

// File: verification/mbus_layer_wrapper_tb.sv
`timescale 1ns/1ns

module mbus_layer_wrapper_tb
	import mbus_frame_pkg::*;
	import mbus_power_pkg::*;
();

	localparam logic [3:0] TB_PREFIX = 4'h5;

	logic clkin = 1'b0;
	logic rst, din, tx_req, rx_ack, sleep_req, req_int;
	mbus_addr_t tx_addr, rx_addr, exp_addr;
	logic [31:0] tx_data, rx_data, exp_data;
	logic tx_ack, tx_succ, rx_req, rx_broadcast, rx_fail, node_sleep, node_isolate, dout;
	logic exp_bcast, no_rx, fwd_check;
	logic [41:0] cap;
	integer seed = 32'h205a;

	always #10 clkin = ~clkin;

	mbus_layer_wrapper #(.NODE_PREFIX(TB_PREFIX)) mbus_layer_wrapper_i (
		.clkin(clkin), .rst(rst), .din(din), .dout(dout),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_req(tx_req), .rx_ack(rx_ack),
		.sleep_req(sleep_req), .req_int(req_int), .tx_ack(tx_ack), .tx_succ(tx_succ),
		.rx_req(rx_req), .rx_broadcast(rx_broadcast), .rx_fail(rx_fail),
		.rx_addr(rx_addr), .rx_data(rx_data),
		.node_sleep(node_sleep), .node_isolate(node_isolate)
	);

	task automatic fail_test(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	`include "mbus_tb_tasks.svh"

	// 0 rx_req, 1 rx_fail, 2 node_sleep, 3 node awake
	function automatic logic watch(input int which);
		case (which)
			0: return rx_req;
			1: return rx_fail;
			2: return node_sleep;
			default: return !node_isolate;
		endcase
	endfunction

	task automatic wait_high(input int which, input string name);
		int n;
		n = 0;
		while (watch(which) !== 1'b1 && n < 200)
		begin
			@(negedge clkin);
			n++;
		end
		if (watch(which) !== 1'b1)
			fail_test($sformatf("timeout waiting for %s", name));
	endtask

	task automatic ack_message();
		repeat (3) @(negedge clkin);
		rx_ack = 1'b1;
		@(negedge clkin);
		rx_ack = 1'b0;
	endtask

	task automatic receive_frame(input logic [7:0] addr, input logic bcast);
		exp_addr = addr;
		exp_data = $random(seed);
		exp_bcast = bcast;
		send_frame(exp_addr, exp_data);
		wait_high(0, "rx_req");
	endtask

	after_reset: assert property (@(posedge clkin) $fell(rst) |->
		!rx_req && !rx_fail && !tx_ack && !tx_succ && !node_sleep && !node_isolate && dout)
		else fail_test("outputs not in their reset state after reset");
	rx_addr_ok: assert property (@(posedge clkin) disable iff (rst)
		($rose(rx_req) || rx_fail) |-> rx_addr == exp_addr)
		else fail_test($sformatf("MISMATCH rx_addr got %h expected %h",
			$sampled(rx_addr), exp_addr));
	rx_data_ok: assert property (@(posedge clkin) disable iff (rst)
		($rose(rx_req) || rx_fail) |-> rx_data == exp_data)
		else fail_test($sformatf("MISMATCH rx_data got %h expected %h",
			$sampled(rx_data), exp_data));
	rx_bcast_ok: assert property (@(posedge clkin) disable iff (rst)
		$rose(rx_req) |-> rx_broadcast == exp_bcast)
		else fail_test($sformatf("MISMATCH rx_broadcast got %h expected %h",
			$sampled(rx_broadcast), exp_bcast));
	rx_hold: assert property (@(posedge clkin) disable iff (rst)
		rx_req && !rx_ack |=> rx_req && $stable(rx_addr) && $stable(rx_data))
		else fail_test("rx message changed before rx_ack");
	rx_release: assert property (@(posedge clkin) disable iff (rst)
		rx_req && rx_ack |=> !rx_req)
		else fail_test($sformatf("MISMATCH rx_req got %h expected 0", $sampled(rx_req)));
	rx_quiet: assert property (@(posedge clkin) disable iff (rst) no_rx |-> !rx_req)
		else fail_test("rx_req raised for a frame that must not be received");
	rx_fail_pulse: assert property (@(posedge clkin) disable iff (rst) rx_fail |=> !rx_fail)
		else fail_test("rx_fail longer than one cycle");
	forward_ok: assert property (@(posedge clkin) disable iff (rst)
		fwd_check |-> dout == $past(din))
		else fail_test($sformatf("MISMATCH dout got %h expected %h",
			$sampled(dout), $past(din)));
	tx_ack_pulse: assert property (@(posedge clkin) disable iff (rst) tx_ack |=> !tx_ack)
		else fail_test("tx_ack longer than one cycle");
	tx_timing: assert property (@(posedge clkin) disable iff (rst)
		tx_ack |-> ##2 !dout ##41 (dout && tx_succ))
		else fail_test("transmitted frame or tx_succ out of place on dout");
	sleep_timing: assert property (@(posedge clkin) disable iff (rst)
		$rose(sleep_req) && !node_isolate |-> ##[1:3] node_sleep)
		else fail_test("node_sleep not high within 3 cycles of sleep_req");
	wake_timing: assert property (@(posedge clkin) disable iff (rst)
		node_sleep && $rose(req_int) |-> ##(WAKE_CYCLES-1) node_isolate ##1 !node_isolate)
		else fail_test("node_isolate not released exactly WAKE_CYCLES after req_int");

	initial
	begin
		rst = 1'b1;
		din = 1'b1;
		tx_req = 1'b0;
		rx_ack = 1'b0;
		sleep_req = 1'b0;
		req_int = 1'b0;
		tx_addr = '0;
		tx_data = '0;
		exp_addr = '0;
		exp_data = '0;
		exp_bcast = 1'b0;
		no_rx = 1'b0;
		fwd_check = 1'b1;
		repeat (10) @(negedge clkin);
		rst = 1'b0;
		// receiver needs a frame length of idle line before it syncs
		idle_line(50);
		receive_frame({TB_PREFIX, 4'h3}, 1'b0);
		ack_message();
		idle_line(5);
		receive_frame({BCAST_PREFIX, 4'h7}, 1'b1);
		ack_message();
		no_rx = 1'b1;
		send_frame({4'h9, 4'h2}, $random(seed));
		idle_line(5);
		no_rx = 1'b0;
		// second frame arrives while the first one is still held
		receive_frame({TB_PREFIX, 4'ha}, 1'b0);
		send_frame({TB_PREFIX, 4'hb}, $random(seed));
		wait_high(1, "rx_fail");
		ack_message();
		idle_line(5);
		fwd_check = 1'b0;
		transmit_frame({4'hc, 4'h1}, $random(seed), cap);
		assert (cap == {1'b0, tx_addr, tx_data, 1'b1})
		else
			fail_test($sformatf("MISMATCH dout frame got %h expected %h",
				cap, {1'b0, tx_addr, tx_data, 1'b1}));
		idle_line(3);
		fwd_check = 1'b1;
		// sleep, then wake by interrupt
		@(negedge clkin);
		sleep_req = 1'b1;
		@(negedge clkin);
		sleep_req = 1'b0;
		wait_high(2, "node_sleep");
		idle_line(5);
		req_int = 1'b1;
		wait_high(3, "node wake");
		req_int = 1'b0;
		// sleep again; this frame is forwarded and its start bit wakes the node
		idle_line(5);
		sleep_req = 1'b1;
		@(negedge clkin);
		sleep_req = 1'b0;
		wait_high(2, "node_sleep");
		no_rx = 1'b1;
		send_frame({TB_PREFIX, 4'h4}, $random(seed));
		idle_line(50);
		no_rx = 1'b0;
		receive_frame({TB_PREFIX, 4'h6}, 1'b0);
		ack_message();
		idle_line(5);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: design/mbus_layer_wrapper.sv
`timescale 1ns/1ns

module mbus_layer_wrapper
	import mbus_frame_pkg::*;
	import mbus_power_pkg::*;
#(
	parameter logic [3:0] NODE_PREFIX = 4'h5
)
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	output logic dout,
	input  mbus_addr_t tx_addr,
	input  logic [DATA_WIDTH-1:0] tx_data,
	input  logic tx_req,
	input  logic rx_ack,
	input  logic sleep_req,
	input  logic req_int,
	output logic tx_ack,
	output logic tx_succ,
	output logic rx_req,
	output logic rx_broadcast,
	output logic rx_fail,
	output mbus_addr_t rx_addr,
	output logic [DATA_WIDTH-1:0] rx_data,
	output logic node_sleep,
	output logic node_isolate
);

	logic rx_busy;
	logic tx_active;
	logic tx_bit;
	logic din_fall;
	logic node_reset;
	logic node_rst;
	logic wake;

	mbus_msg_if msg ();

	// power-gated node, held in reset while it is down
	assign node_rst = rst | node_reset;

	mbus_rx_frame mbus_rx_frame_i (
		.clkin       (clkin),
		.rst         (node_rst),
		.din         (din),
		.node_prefix (NODE_PREFIX),
		.rx_busy     (rx_busy),
		.msg         (msg.rx_side)
	);

	mbus_tx_frame mbus_tx_frame_i (
		.clkin     (clkin),
		.rst       (node_rst),
		.rx_busy   (rx_busy),
		.tx_active (tx_active),
		.tx_bit    (tx_bit),
		.msg       (msg.tx_side)
	);

	// always-on part
	mbus_wire_ctrl mbus_wire_ctrl_i (
		.clkin     (clkin),
		.rst       (rst),
		.din       (din),
		.tx_active (tx_active),
		.tx_bit    (tx_bit),
		.dout      (dout),
		.din_fall  (din_fall)
	);

	// raw tx_req here, the clamped copy is held low during sleep
	assign wake = req_int | tx_req | din_fall;

	mbus_sleep_ctrl mbus_sleep_ctrl_i (
		.clkin        (clkin),
		.rst          (rst),
		.sleep_req    (sleep_req),
		.wake         (wake),
		.busy         (rx_busy | tx_active),
		.node_sleep   (node_sleep),
		.node_isolate (node_isolate),
		.node_reset   (node_reset)
	);

	// isolation clamps toward the node
	assign msg.tx_addr = tx_addr;
	assign msg.tx_data = tx_data;
	assign msg.tx_req = tx_req & ~node_isolate;
	assign msg.rx_ack = rx_ack & ~node_isolate;

	// and toward the layer controller
	assign tx_ack = msg.tx_ack & ~node_isolate;
	assign tx_succ = msg.tx_succ & ~node_isolate;
	assign rx_req = msg.rx_req & ~node_isolate;
	assign rx_broadcast = msg.rx_broadcast & ~node_isolate;
	assign rx_fail = msg.rx_fail & ~node_isolate;
	assign rx_addr = node_isolate ? '0 : msg.rx_addr;
	assign rx_data = node_isolate ? '0 : msg.rx_data;

	// wake timing as seen at the clamps
	wake_releases_iso: assert property (@(posedge clkin) disable iff (rst)
		node_sleep && wake |-> ##WAKE_CYCLES !node_isolate)
		else $error("isolation not released on time after wake");

endmodule

// File: design/mbus_sleep_ctrl.sv
`timescale 1ns/1ns

module mbus_sleep_ctrl
	import mbus_power_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic sleep_req,
	input  logic wake,
	input  logic busy,
	output logic node_sleep,
	output logic node_isolate,
	output logic node_reset
);

	sleep_state_t state_q;
	sleep_state_t state_d;
	logic [WAKE_CNT_WIDTH-1:0] wake_cnt;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_AWAKE:
				if (sleep_req && !busy)
					state_d = ST_ISOLATE;
			ST_ISOLATE:
				state_d = ST_RESET;
			ST_RESET:
				state_d = ST_SLEEP;
			ST_SLEEP:
				if (wake)
					state_d = ST_WAKE_POWER;
			ST_WAKE_POWER:
				if (wake_cnt == '0)
					state_d = ST_WAKE_RESET;
			ST_WAKE_RESET:
				state_d = ST_AWAKE;
			default:
				state_d = ST_AWAKE;
		endcase
	end

	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			state_q <= ST_AWAKE;
			wake_cnt <= '0;
		end
		else
		begin
			state_q <= state_d;
			// power-up time, loaded on the way out of sleep
			if (state_q == ST_SLEEP)
				wake_cnt <= WAKE_CNT_WIDTH'(WAKE_POWER_CYCLES - 1);
			else if (wake_cnt != '0)
				wake_cnt <= wake_cnt - 1'b1;
		end
	end

	assign node_sleep = (state_q == ST_SLEEP);
	assign node_isolate = (state_q != ST_AWAKE);
	assign node_reset = (state_q == ST_RESET) || (state_q == ST_SLEEP)
		|| (state_q == ST_WAKE_POWER);

	// the powered-down node is always held in reset behind the clamps
	sleep_behind_iso: assert property (@(posedge clkin) disable iff (rst)
		node_sleep |-> node_isolate && node_reset)
		else $error("node asleep without isolation and reset");

endmodule

// File: design/mbus_wire_ctrl.sv
`timescale 1ns/1ns

module mbus_wire_ctrl
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	input  logic tx_active,
	input  logic tx_bit,
	output logic dout,
	output logic din_fall
);

	logic din_q;

	// always on, so the ring keeps working while the node sleeps
	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			dout <= 1'b1;
			din_q <= 1'b1;
			din_fall <= 1'b0;
		end
		else
		begin
			// own frame wins, otherwise repeat upstream with one cycle delay
			if (tx_active)
				dout <= tx_bit;
			else
				dout <= din;

			din_q <= din;
			// high the cycle after a start bit shows up
			din_fall <= din_q & ~din;
		end
	end

endmodule

// File: node/mbus_tx_frame.sv
`timescale 1ns/1ns

module mbus_tx_frame
	import mbus_frame_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic rx_busy,
	output logic tx_active,
	output logic tx_bit,
	mbus_msg_if.tx_side msg
);

	logic [FRAME_BITS-1:0] shift_q;
	logic [CNT_WIDTH-1:0] bit_cnt;
	logic active_q;
	logic succ_q;
	logic start;
	logic last_bit;

	// take the request only while nothing is on the wire
	assign start = msg.tx_req && !rx_busy && !active_q;

	// stop bit is on tx_bit in this cycle
	assign last_bit = active_q && (bit_cnt == CNT_WIDTH'(FRAME_BITS - 1));

	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			active_q <= 1'b0;
			bit_cnt <= '0;
			succ_q <= 1'b0;
		end
		else
		begin
			succ_q <= last_bit;
			if (start)
			begin
				active_q <= 1'b1;
				bit_cnt <= '0;
			end
			else if (active_q)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last_bit)
					active_q <= 1'b0;
			end
		end
	end

	// MSB first; the line idles high, so ones fill in behind
	always_ff @(posedge clkin)
	begin
		if (start)
			shift_q <= {1'b0, msg.tx_addr, msg.tx_data, 1'b1};
		else if (active_q)
			shift_q <= {shift_q[FRAME_BITS-2:0], 1'b1};
	end

	assign tx_active = active_q;
	assign tx_bit = shift_q[FRAME_BITS-1];

	assign msg.tx_ack = start;
	assign msg.tx_succ = succ_q;

	// a new request is never acknowledged on top of a running frame
	tx_ack_when_idle: assert property (@(posedge clkin) disable iff (rst)
		msg.tx_ack |-> !tx_active)
		else $error("tx_ack while a frame is being sent");

endmodule

// File: node/mbus_rx_frame.sv
`timescale 1ns/1ns

module mbus_rx_frame
	import mbus_frame_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	input  logic [3:0] node_prefix,
	output logic rx_busy,
	mbus_msg_if.rx_side msg
);

	logic busy_q;
	logic [CNT_WIDTH-1:0] bit_cnt;
	logic [CNT_WIDTH-1:0] idle_cnt;
	logic synced;
	logic [PAYLOAD_BITS-1:0] shift_q;
	mbus_addr_t frame_addr;
	logic is_bcast;
	logic addr_match;
	logic stop_seen;
	logic frame_ok;

	logic rx_req_q;
	logic rx_fail_q;
	mbus_addr_t rx_addr_q;
	logic [DATA_WIDTH-1:0] rx_data_q;
	logic rx_bcast_q;

	// coming out of reset the line may be in the middle of a frame, e.g. the one
	// whose start bit woke the node, so a start bit is only taken after a full
	// frame length of idle line
	assign synced = (idle_cnt == CNT_WIDTH'(FRAME_BITS));

	// address byte sits on top of the shift register once all payload bits are in
	assign frame_addr = shift_q[PAYLOAD_BITS-1 -: ADDR_WIDTH];
	assign is_bcast = (frame_addr.bcast_addr.marker == BCAST_PREFIX);
	assign addr_match = is_bcast || (frame_addr.short_addr.prefix == node_prefix);

	// bit_cnt counts payload bits after the start bit
	assign stop_seen = busy_q && (bit_cnt == CNT_WIDTH'(PAYLOAD_BITS));
	assign frame_ok = stop_seen && din && addr_match;

	// a low line while idle is the start bit itself
	assign rx_busy = busy_q | ~din;

	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			busy_q <= 1'b0;
			bit_cnt <= '0;
			idle_cnt <= '0;
			rx_req_q <= 1'b0;
			rx_fail_q <= 1'b0;
		end
		else
		begin
			if (!synced)
				idle_cnt <= din ? idle_cnt + 1'b1 : '0;

			if (busy_q)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (stop_seen)
					busy_q <= 1'b0;
			end
			else if (synced && !din)
			begin
				busy_q <= 1'b1;
				bit_cnt <= '0;
			end

			// overrun: the held message stays, the new one is dropped
			rx_fail_q <= frame_ok && rx_req_q;

			if (frame_ok && !rx_req_q)
				rx_req_q <= 1'b1;
			else if (msg.rx_ack)
				rx_req_q <= 1'b0;
		end
	end

	always_ff @(posedge clkin)
	begin
		if (busy_q && !stop_seen)
			shift_q <= {shift_q[PAYLOAD_BITS-2:0], din};

		if (frame_ok && !rx_req_q)
		begin
			rx_addr_q <= frame_addr;
			rx_data_q <= shift_q[DATA_WIDTH-1:0];
			rx_bcast_q <= is_bcast;
		end
	end

	assign msg.rx_req = rx_req_q;
	assign msg.rx_fail = rx_fail_q;
	assign msg.rx_addr = rx_addr_q;
	assign msg.rx_data = rx_data_q;
	assign msg.rx_broadcast = rx_bcast_q;

	// an overrun needs a message that was already waiting
	rx_fail_needs_req: assert property (@(posedge clkin) disable iff (rst)
		msg.rx_fail |-> $past(msg.rx_req))
		else $error("rx_fail raised with no message held");

endmodule

// File: common/mbus_msg_if.sv
`timescale 1ns/1ns

interface mbus_msg_if import mbus_frame_pkg::*; ();

	// transmit side, from the layer controller
	mbus_addr_t tx_addr;
	logic [DATA_WIDTH-1:0] tx_data;
	logic tx_req;
	logic tx_ack;
	logic tx_succ;

	// receive side, toward the layer controller
	mbus_addr_t rx_addr;
	logic [DATA_WIDTH-1:0] rx_data;
	logic rx_req;
	logic rx_ack;
	logic rx_broadcast;
	logic rx_fail;

	modport rx_side (
		output rx_addr, rx_data, rx_req, rx_broadcast, rx_fail,
		input  rx_ack
	);

	modport tx_side (
		input  tx_addr, tx_data, tx_req,
		output tx_ack, tx_succ
	);

	// isolation logic in front of the layer controller
	modport lc_side (
		output tx_addr, tx_data, tx_req, rx_ack,
		input  tx_ack, tx_succ, rx_addr, rx_data, rx_req, rx_broadcast, rx_fail
	);

endinterface

// File: common/mbus_power_pkg.sv
package mbus_power_pkg;

	// power sequence of the gated node
	// isolate, then reset, then sleep; the wake path runs it backwards
	typedef enum logic [2:0] {
		ST_AWAKE,
		ST_ISOLATE,
		ST_RESET,
		ST_SLEEP,
		ST_WAKE_POWER,
		ST_WAKE_RESET
	} sleep_state_t;

	// cycles from a sampled wake event until isolation is released
	localparam int WAKE_CYCLES = 3;

	// the wake path spends one cycle each in ST_WAKE_RESET and in the step into
	// ST_AWAKE, the rest is power-up time
	localparam int WAKE_POWER_CYCLES = WAKE_CYCLES - 2;

	localparam int WAKE_CNT_WIDTH = $clog2(WAKE_POWER_CYCLES) + 1;

endpackage

// File: common/mbus_frame_pkg.sv
package mbus_frame_pkg;

	// field widths of one frame
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	// start bit, address, data, stop bit
	localparam int FRAME_BITS = 42;

	// address and data together, as collected by the receiver
	localparam int PAYLOAD_BITS = ADDR_WIDTH + DATA_WIDTH;

	// wide enough to count a full frame length
	localparam int CNT_WIDTH = $clog2(FRAME_BITS + 1);

	// upper nibble that marks a broadcast address
	localparam logic [3:0] BCAST_PREFIX = 4'h0;

	// one address byte, read either as a unit address or as a broadcast channel
	typedef union packed {
		struct packed {
			logic [3:0] prefix;
			logic [3:0] fu_id;
		} short_addr;
		struct packed {
			logic [3:0] marker;
			logic [3:0] channel;
		} bcast_addr;
	} mbus_addr_t;

endpackage
